/* verilog.f */
+incdir+src
src/fe_pkg.sv
src/instr_decoder.sv
src/target_calc.sv
src/issue_ctrl.sv
src/fetch_front.sv
dv/fetch_front_sva.sv
dv/fetch_front_checker.sv
dv/fetch_front_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch_front testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module fetch_front_tb \
    -Mdir obj_dir -o sim_fetch_front &&
./obj_dir/sim_fetch_front > sim.log 2>&1 ||
echo "simulation exited with an error"
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "RESULT: PASS" && exit 0 ||
{ echo "RESULT: FAIL"; exit 1; }

/* dv/fetch_front_tb.sv */
`include "fe_defines.svh"

module fetch_front_tb;

    logic              clk = 1'b0;
    logic              rst;
    logic              mem_read;
    fe_pkg::word_t     mem_addr;
    logic              mem_resp = 1'b0;
    fe_pkg::word_t     mem_rdata = '0;
    logic              iq_push;
    fe_pkg::issue_op_t iq_op;
    fe_pkg::reg_idx_t  iq_src1;
    fe_pkg::reg_idx_t  iq_src2;
    logic              iq_src2_valid;
    fe_pkg::word_t     iq_src2_data;
    fe_pkg::reg_idx_t  iq_rd;
    fe_pkg::word_t     iq_pc;
    fe_pkg::word_t     iq_pc_data;
    logic              iq_pred_taken;
    fe_pkg::word_t     iq_instr;
    logic              credit_return = 1'b0;
    logic              br_pred_take = 1'b0;
    logic              jalr_done = 1'b0;
    fe_pkg::word_t     jalr_target = '0;
    logic              flush;
    fe_pkg::word_t     flush_pc;

    int   seed = 32'hf1f6_d491;
    int   mode = 0;
    logic hold_credits = 1'b0;
    int   push_count = 0;
    int   ret_count = 0;
    int   jalr_pushes = 0;
    int   jalr_served = 0;
    int   lat_cnt = 0;
    int   jalr_cnt = 0;

    always #20 clk = ~clk;

    fetch_front DUT (.*);

    fetch_front_checker chk (.*);

    bind issue_ctrl fetch_front_sva u_sva (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .credits  (credits),
        .pc       (pc),
        .jalr_done(jalr_done),
        .flush    (flush),
        .iq_push  (iq_push),
        .mem_read (mem_read)
    );

    // instruction mix follows the current test
    function automatic fe_pkg::word_t make_instr(input int m, input fe_pkg::word_t r,
                                                 input fe_pkg::word_t s);
        logic [6:0] opc;
        logic [2:0] f3;
        f3 = r[14:12];
        if (m == 1) begin
            case (s[1:0])
                2'd0:    opc = `FE_OPC_LUI;
                2'd1:    opc = `FE_OPC_AUIPC;
                2'd2:    opc = `FE_OPC_JAL;
                default: opc = `FE_OPC_BR;
            endcase
        end else if (m == 3) begin
            opc = s[0] ? `FE_OPC_JALR : `FE_OPC_IMM;
        end else begin
            case (s[3:0] % 4'd5)
                4'd0: opc = `FE_OPC_REG;
                4'd1: opc = s[4] ? `FE_OPC_IMM : `FE_OPC_CSR;
                4'd2: begin
                    opc = `FE_OPC_LOAD;
                    f3  = (s[7:5] == 3'd3) ? `FE_F3_BU : (s[7:5] == 3'd6) ? `FE_F3_HU : f3;
                end
                4'd3:    opc = `FE_OPC_STORE;
                default: opc = `FE_OPC_IMM;
            endcase
        end
        return {r[31:15], f3, r[11:7], opc};
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            if (iq_push) begin
                push_count++;
                if (iq_op == `FE_OP_JALR) begin
                    jalr_pushes++;
                end
            end
            if (credit_return) begin
                ret_count++;
            end
        end
    end

    // memory responder, credit returner and jalr completion
    always @(negedge clk) begin
        fe_pkg::word_t r;
        fe_pkg::word_t s;
        r            = $random(seed);
        s            = $random(seed);
        br_pred_take = s[9];
        mem_resp     = 1'b0;
        jalr_done    = 1'b0;
        if (lat_cnt == 0) begin
            mem_resp  = 1'b1;
            mem_rdata = make_instr(mode, r, s);
            lat_cnt   = int'(s[21:20]);
        end else begin
            lat_cnt--;
        end
        credit_return = !hold_credits && (push_count > ret_count) && (s[13:12] == 2'd0);
        if (jalr_pushes > jalr_served) begin
            if (jalr_cnt == 0) begin
                jalr_done   = 1'b1;
                jalr_target = {r[31:2], 2'b00};
                jalr_served++;
                jalr_cnt = int'(s[17:16]);
            end else begin
                jalr_cnt--;
            end
        end
    end

    task automatic wait_pushes(input int n, input int limit);
        int target;
        int cycles;
        target = push_count + n;
        cycles = 0;
        while (push_count < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (push_count < target) begin
            chk.note_failure("timeout waiting for push");
        end
    endtask

    initial begin
        int   start;
        int   cycles;
        fe_pkg::word_t r;
        rst         = 1'b1;
        flush       = 1'b0;
        flush_pc    = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        chk.start_test("decode");
        mode = 0;
        wait_pushes(40, 1000);
        chk.end_test();

        chk.start_test("predict");
        mode = 1;
        wait_pushes(40, 1000);
        chk.end_test();

        chk.start_test("credits");
        mode   = 0;
        cycles = 0;
        while (push_count != ret_count && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (push_count != ret_count) begin
            chk.note_failure("credits were never all returned");
        end
        hold_credits = 1'b1;
        start = push_count;
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
        end
        chk.check_field("pushes_held", 32'(`FE_IQ_DEPTH), 32'(push_count - start));
        hold_credits = 1'b0;
        wait_pushes(8, 400);
        chk.end_test();

        chk.start_test("jalr");
        mode = 3;
        wait_pushes(24, 1000);
        chk.end_test();

        chk.start_test("flush");
        mode = 0;
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            repeat (int'(r[2:0])) @(negedge clk);
            flush = 1'b1;
            // the pc follows flush_pc, so vary it while flush is held
            for (int j = 0; j <= int'(r[4:3]); j++) begin
                r        = $random(seed);
                flush_pc = {r[31:2], 2'b00};
                @(negedge clk);
            end
            flush = 1'b0;
            wait_pushes(2, 200);
        end
        chk.end_test();

        chk.summary();
        if (chk.error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* dv/fetch_front_checker.sv */
`include "fe_defines.svh"

module fetch_front_checker (
    input logic              clk,
    input logic              rst,
    input logic              mem_read,
    input fe_pkg::word_t     mem_addr,
    input logic              mem_resp,
    input fe_pkg::word_t     mem_rdata,
    input logic              iq_push,
    input fe_pkg::issue_op_t iq_op,
    input fe_pkg::reg_idx_t  iq_src1,
    input fe_pkg::reg_idx_t  iq_src2,
    input logic              iq_src2_valid,
    input fe_pkg::word_t     iq_src2_data,
    input fe_pkg::reg_idx_t  iq_rd,
    input fe_pkg::word_t     iq_pc,
    input fe_pkg::word_t     iq_pc_data,
    input logic              iq_pred_taken,
    input fe_pkg::word_t     iq_instr,
    input logic              credit_return,
    input logic              br_pred_take,
    input logic              jalr_done,
    input fe_pkg::word_t     jalr_target,
    input logic              flush,
    input fe_pkg::word_t     flush_pc
);

    string         test_name = "reset";
    int            cur_errors = 0;
    int            error_count = 0;
    int            tests_run = 0;
    int            tests_failing = 0;
    int            pushes;
    int            returns;
    fe_pkg::word_t exp_addr;
    fe_pkg::word_t held_instr;
    fe_pkg::word_t held_pc;
    logic          wait_jalr;

    task automatic check_field(input string field, input fe_pkg::word_t exp,
                               input fe_pkg::word_t act);
        if (exp !== act) begin
            cur_errors++;
            error_count++;
            $display("FAILED %s %s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic note_failure(input string what);
        cur_errors++;
        error_count++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        cur_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (cur_errors != 0) begin
            tests_failing++;
        end
        $display("test %s finished with %0d errors", test_name, cur_errors);
    endtask

    task automatic summary();
        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failing,
                 error_count);
    endtask

    // reference decode, written from the RV32I encodings
    task automatic model(input fe_pkg::word_t ins, input fe_pkg::word_t pc, input logic take,
                         output fe_pkg::issue_op_t op, output fe_pkg::reg_idx_t r1,
                         output fe_pkg::reg_idx_t r2, output fe_pkg::reg_idx_t rd,
                         output logic sv, output fe_pkg::word_t sd,
                         output fe_pkg::word_t pcd, output fe_pkg::word_t nxt);
        logic [6:0]    opc;
        logic [2:0]    f3;
        fe_pkg::word_t iimm;
        fe_pkg::word_t simm;
        fe_pkg::word_t bimm;
        fe_pkg::word_t jimm;
        fe_pkg::word_t uimm;
        opc  = ins[6:0];
        f3   = ins[14:12];
        iimm = {{20{ins[31]}}, ins[31:20]};
        simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bimm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jimm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        uimm = {ins[31:12], 12'h000};
        op   = `FE_OP_ARITH;
        r1   = ins[19:15];
        r2   = ins[24:20];
        rd   = ins[11:7];
        sv   = 1'b0;
        sd   = '0;
        pcd  = pc + 32'd4;
        nxt  = pc + 32'd4;
        if (opc == `FE_OPC_LUI || opc == `FE_OPC_AUIPC || opc == `FE_OPC_JAL) begin
            r1 = '0;
            r2 = '0;
            sv = 1'b1;
            if (opc == `FE_OPC_LUI) begin
                op  = `FE_OP_LUI;
                pcd = uimm;
            end else if (opc == `FE_OPC_AUIPC) begin
                op  = `FE_OP_AUIPC;
                pcd = pc + uimm;
            end else begin
                op  = `FE_OP_JAL;
                nxt = pc + jimm;
            end
        end else if (opc == `FE_OPC_BR) begin
            op  = `FE_OP_BRANCH;
            nxt = take ? pc + bimm : pc + 32'd4;
            pcd = take ? pc + 32'd4 : pc + bimm;
        end else if (opc == `FE_OPC_STORE) begin
            op = (f3 == 3'b000) ? `FE_OP_SB : (f3 == 3'b001) ? `FE_OP_SH : `FE_OP_SW;
            sv = 1'b1;
            sd = simm;
        end else if (opc == `FE_OPC_LOAD || opc == `FE_OPC_JALR || opc == `FE_OPC_IMM
                     || opc == `FE_OPC_CSR) begin
            r2 = '0;
            sv = 1'b1;
            sd = iimm;
            if (opc == `FE_OPC_JALR) begin
                op = `FE_OP_JALR;
            end else if (opc == `FE_OPC_LOAD) begin
                case (f3)
                    3'b000:  op = `FE_OP_LB;
                    3'b001:  op = `FE_OP_LH;
                    3'b100:  op = `FE_OP_LBU;
                    3'b101:  op = `FE_OP_LHU;
                    default: op = `FE_OP_LW;
                endcase
            end
        end
    endtask

    always @(posedge clk) begin
        fe_pkg::issue_op_t m_op;
        fe_pkg::reg_idx_t  m_r1;
        fe_pkg::reg_idx_t  m_r2;
        fe_pkg::reg_idx_t  m_rd;
        logic              m_sv;
        fe_pkg::word_t     m_sd;
        fe_pkg::word_t     m_pcd;
        fe_pkg::word_t     m_nxt;
        if (rst) begin
            exp_addr  = `FE_RESET_PC;
            wait_jalr = 1'b0;
            pushes    = 0;
            returns   = 0;
        end else begin
            if (credit_return) begin
                returns++;
            end
            if (flush) begin
                if (iq_push) begin
                    note_failure("push while flush is high");
                end
                exp_addr  = flush_pc;
                wait_jalr = 1'b0;
            end else begin
                if (mem_read && wait_jalr) begin
                    note_failure("fetch issued while waiting for jalr_done");
                end
                if (mem_read && mem_resp) begin
                    check_field("mem_addr", exp_addr, mem_addr);
                    held_instr = mem_rdata;
                    held_pc    = mem_addr;
                end
                if (iq_push) begin
                    pushes++;
                    model(held_instr, held_pc, br_pred_take, m_op, m_r1, m_r2, m_rd, m_sv,
                          m_sd, m_pcd, m_nxt);
                    check_field("op", 32'(m_op), 32'(iq_op));
                    check_field("src1", 32'(m_r1), 32'(iq_src1));
                    check_field("src2", 32'(m_r2), 32'(iq_src2));
                    check_field("rd", 32'(m_rd), 32'(iq_rd));
                    check_field("src2_valid", 32'(m_sv), 32'(iq_src2_valid));
                    check_field("src2_data", m_sd, iq_src2_data);
                    check_field("pc", held_pc, iq_pc);
                    check_field("pc_data", m_pcd, iq_pc_data);
                    check_field("instr", held_instr, iq_instr);
                    // prediction bit only carries meaning on branches
                    if (m_op == `FE_OP_BRANCH) begin
                        check_field("pred_taken", 32'(br_pred_take), 32'(iq_pred_taken));
                    end
                    if (m_op == `FE_OP_JALR) begin
                        wait_jalr = 1'b1;
                    end else begin
                        exp_addr = m_nxt;
                    end
                    if (pushes > returns + `FE_IQ_DEPTH) begin
                        note_failure("more pushes than credits");
                    end
                end
                if (jalr_done && wait_jalr) begin
                    exp_addr  = jalr_target;
                    wait_jalr = 1'b0;
                end
            end
        end
    end

endmodule

/* dv/fetch_front_sva.sv */
`include "fe_defines.svh"

module fetch_front_sva (
    input logic              clk,
    input logic              rst,
    input fe_pkg::fe_state_e state,
    input fe_pkg::credit_t   credits,
    input fe_pkg::word_t     pc,
    input logic              jalr_done,
    input logic              flush,
    input logic              iq_push,
    input logic              mem_read
);

    // a push always consumes an existing credit
    assert property (@(posedge clk) disable iff (rst) iq_push |-> (credits != '0))
        else $error("push with zero credits");

    assert property (@(posedge clk) disable iff (rst)
        credits <= fe_pkg::credit_t'(`FE_IQ_DEPTH))
        else $error("credit count above queue depth");

    // quiet ports right after reset
    assert property (@(posedge clk) rst |=> (!mem_read && !iq_push))
        else $error("activity in the cycle after reset");

    // state and pc hold until the jalr target comes back
    assert property (@(posedge clk) disable iff (rst)
        (state == fe_pkg::WAIT_JALR && !jalr_done && !flush)
        |=> (state == fe_pkg::WAIT_JALR && $stable(pc)))
        else $error("jalr stall left early or moved the pc");

endmodule

/* src/fetch_front.sv */
module fetch_front (
    input  logic              clk,
    input  logic              rst,
    output logic              mem_read,
    output fe_pkg::word_t     mem_addr,
    input  logic              mem_resp,
    input  fe_pkg::word_t     mem_rdata,
    output logic              iq_push,
    output fe_pkg::issue_op_t iq_op,
    output fe_pkg::reg_idx_t  iq_src1,
    output fe_pkg::reg_idx_t  iq_src2,
    output logic              iq_src2_valid,
    output fe_pkg::word_t     iq_src2_data,
    output fe_pkg::reg_idx_t  iq_rd,
    output fe_pkg::word_t     iq_pc,
    output fe_pkg::word_t     iq_pc_data,
    output logic              iq_pred_taken,
    output fe_pkg::word_t     iq_instr,
    input  logic              credit_return,
    input  logic              br_pred_take,
    input  logic              jalr_done,
    input  fe_pkg::word_t     jalr_target,
    input  logic              flush,
    input  fe_pkg::word_t     flush_pc
);

    fe_pkg::word_t pc;
    fe_pkg::word_t instr;
    fe_pkg::word_t next_pc;

    assign mem_addr      = pc;
    assign iq_pc         = pc;
    assign iq_instr      = instr;
    // only meaningful on BRANCH packets
    assign iq_pred_taken = br_pred_take;

    issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .credit_return(credit_return),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .jalr_done    (jalr_done),
        .jalr_target  (jalr_target),
        .next_pc      (next_pc),
        .mem_read     (mem_read),
        .pc           (pc),
        .instr        (instr),
        .iq_push      (iq_push),
        .is_jalr      ()
    );

    // funct3 reaches the back end inside iq_instr
    instr_decoder u_instr_decoder (
        .instr     (instr),
        .op        (iq_op),
        .rs1       (iq_src1),
        .rs2       (iq_src2),
        .rd        (iq_rd),
        .src2_valid(iq_src2_valid),
        .src2_data (iq_src2_data),
        .funct3    ()
    );

    target_calc u_target_calc (
        .instr    (instr),
        .pc       (pc),
        .pred_take(br_pred_take),
        .next_pc  (next_pc),
        .pc_data  (iq_pc_data)
    );

endmodule

/* src/issue_ctrl.sv */
`include "fe_defines.svh"

module issue_ctrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_resp,
    input  fe_pkg::word_t mem_rdata,
    input  logic          credit_return,
    input  logic          flush,
    input  fe_pkg::word_t flush_pc,
    input  logic          jalr_done,
    input  fe_pkg::word_t jalr_target,
    input  fe_pkg::word_t next_pc,
    output logic          mem_read,
    output fe_pkg::word_t pc,
    output fe_pkg::word_t instr,
    output logic          iq_push,
    output logic          is_jalr
);

    fe_pkg::fe_state_e state;
    fe_pkg::fe_state_e next_state;
    fe_pkg::credit_t   credits;
    logic              have_credit;

    assign is_jalr     = (instr[6:0] == `FE_OPC_JALR);
    assign have_credit = (credits != '0);

    // a flush abandons the fetch and blocks the push in the same cycle
    assign mem_read = (state == fe_pkg::FETCH) && !flush;
    assign iq_push  = (state == fe_pkg::ISSUE) && have_credit && !flush;

    always_comb begin
        next_state = state;
        case (state)
            fe_pkg::RESET: begin
                next_state = fe_pkg::FETCH;
            end
            fe_pkg::FETCH: begin
                if (mem_resp) begin
                    next_state = fe_pkg::ISSUE;
                end
            end
            fe_pkg::ISSUE: begin
                // stays here while the queue is full
                if (iq_push) begin
                    next_state = is_jalr ? fe_pkg::WAIT_JALR : fe_pkg::FETCH;
                end
            end
            fe_pkg::WAIT_JALR: begin
                if (jalr_done) begin
                    next_state = fe_pkg::FETCH;
                end
            end
            fe_pkg::FLUSH: begin
                next_state = fe_pkg::FETCH;
            end
            default: begin
                next_state = fe_pkg::RESET;
            end
        endcase
        if (flush) begin
            next_state = fe_pkg::FLUSH;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fe_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    // held instruction
    always_ff @(posedge clk) begin
        if (mem_read && mem_resp) begin
            instr <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FE_RESET_PC;
        end else if (flush) begin
            pc <= flush_pc;
        end else if (iq_push) begin
            pc <= next_pc;
        end else if (state == fe_pkg::WAIT_JALR && jalr_done) begin
            pc <= jalr_target;
        end
    end

    // one credit per free queue slot
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= fe_pkg::credit_t'(`FE_IQ_DEPTH);
        end else begin
            case ({iq_push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* src/target_calc.sv */
`include "fe_defines.svh"

module target_calc (
    input  fe_pkg::word_t instr,
    input  fe_pkg::word_t pc,
    input  logic          pred_take,
    output fe_pkg::word_t next_pc,
    output fe_pkg::word_t pc_data
);

    logic [6:0]    opcode;
    fe_pkg::word_t b_imm;
    fe_pkg::word_t j_imm;
    fe_pkg::word_t u_imm;
    fe_pkg::word_t pc_plus4;
    fe_pkg::word_t br_target;

    assign opcode = instr[6:0];

    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + b_imm;

    // predicted fetch address
    always_comb begin
        case (opcode)
            `FE_OPC_JAL: next_pc = pc + j_imm;
            `FE_OPC_BR:  next_pc = pred_take ? br_target : pc_plus4;
            default:     next_pc = pc_plus4;
        endcase
    end

    // for branches this is the path we did not follow, used on mispredict
    always_comb begin
        case (opcode)
            `FE_OPC_LUI:   pc_data = u_imm;
            `FE_OPC_AUIPC: pc_data = pc + u_imm;
            `FE_OPC_BR:    pc_data = pred_take ? pc_plus4 : br_target;
            default:       pc_data = pc_plus4;
        endcase
    end

endmodule

/* src/instr_decoder.sv */
`include "fe_defines.svh"

module instr_decoder (
    input  fe_pkg::word_t     instr,
    output fe_pkg::issue_op_t op,
    output fe_pkg::reg_idx_t  rs1,
    output fe_pkg::reg_idx_t  rs2,
    output fe_pkg::reg_idx_t  rd,
    output logic              src2_valid,
    output fe_pkg::word_t     src2_data,
    output logic [2:0]        funct3
);

    logic [6:0]    opcode;
    fe_pkg::word_t i_imm;
    fe_pkg::word_t s_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];

    // sign-extended immediates used as the second operand
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        op         = `FE_OP_ARITH;
        rs1        = instr[19:15];
        rs2        = instr[24:20];
        src2_valid = 1'b0;
        src2_data  = '0;

        case (opcode)
            `FE_OPC_LUI: begin
                op         = `FE_OP_LUI;
                rs1        = '0;
                rs2        = '0;
                src2_valid = 1'b1;
            end
            `FE_OPC_AUIPC: begin
                op         = `FE_OP_AUIPC;
                rs1        = '0;
                rs2        = '0;
                src2_valid = 1'b1;
            end
            `FE_OPC_JAL: begin
                op         = `FE_OP_JAL;
                rs1        = '0;
                rs2        = '0;
                src2_valid = 1'b1;
            end
            `FE_OPC_JALR: begin
                op         = `FE_OP_JALR;
                rs2        = '0;
                src2_valid = 1'b1;
                src2_data  = i_imm;
            end
            `FE_OPC_BR: begin
                // both sources are registers, compare happens downstream
                op = `FE_OP_BRANCH;
            end
            `FE_OPC_LOAD: begin
                case (funct3)
                    `FE_F3_B:  op = `FE_OP_LB;
                    `FE_F3_H:  op = `FE_OP_LH;
                    `FE_F3_BU: op = `FE_OP_LBU;
                    `FE_F3_HU: op = `FE_OP_LHU;
                    default:   op = `FE_OP_LW;
                endcase
                rs2        = '0;
                src2_valid = 1'b1;
                src2_data  = i_imm;
            end
            `FE_OPC_STORE: begin
                case (funct3)
                    `FE_F3_B: op = `FE_OP_SB;
                    `FE_F3_H: op = `FE_OP_SH;
                    default:  op = `FE_OP_SW;
                endcase
                // rs2 keeps the store data register, offset goes in src2_data
                src2_valid = 1'b1;
                src2_data  = s_imm;
            end
            `FE_OPC_IMM, `FE_OPC_CSR: begin
                rs2        = '0;
                src2_valid = 1'b1;
                src2_data  = i_imm;
            end
            default: begin
                // register-register arithmetic
                op = `FE_OP_ARITH;
            end
        endcase
    end

endmodule

/* src/fe_pkg.sv */
package fe_pkg;

    // instruction, pc or data word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // issue op, values in fe_defines.svh
    typedef logic [3:0] issue_op_t;

    // free queue slots, 0 up to the queue depth
    typedef logic [2:0] credit_t;

    // fetch and issue sequencing
    typedef enum logic [2:0] {
        RESET     = 3'd0,
        FETCH     = 3'd1,
        ISSUE     = 3'd2,
        WAIT_JALR = 3'd3,
        FLUSH     = 3'd4
    } fe_state_e;

endpackage

/* src/fe_defines.svh */
`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

`define FE_RESET_PC 32'h0000_0000
`define FE_IQ_DEPTH 4

// rv32i major opcodes
`define FE_OPC_LUI   7'b0110111
`define FE_OPC_AUIPC 7'b0010111
`define FE_OPC_JAL   7'b1101111
`define FE_OPC_JALR  7'b1100111
`define FE_OPC_BR    7'b1100011
`define FE_OPC_LOAD  7'b0000011
`define FE_OPC_STORE 7'b0100011
`define FE_OPC_IMM   7'b0010011
`define FE_OPC_REG   7'b0110011
`define FE_OPC_CSR   7'b1110011

// load and store widths
`define FE_F3_B  3'b000
`define FE_F3_H  3'b001
`define FE_F3_W  3'b010
`define FE_F3_BU 3'b100
`define FE_F3_HU 3'b101

// issue op codes seen by the reservation stations
`define FE_OP_ARITH  4'd0
`define FE_OP_LUI    4'd1
`define FE_OP_AUIPC  4'd2
`define FE_OP_JAL    4'd3
`define FE_OP_JALR   4'd4
`define FE_OP_BRANCH 4'd5
`define FE_OP_LB     4'd6
`define FE_OP_LH     4'd7
`define FE_OP_LW     4'd8
`define FE_OP_LBU    4'd9
`define FE_OP_LHU    4'd10
`define FE_OP_SB     4'd11
`define FE_OP_SH     4'd12
`define FE_OP_SW     4'd13

`endif
